// File: project.f
+incdir+tests
source/link_pkg.sv
source/link_word_receiver.sv
source/link_sequencer.sv
source/link_bus_master.sv
source/link_word_sender.sv
source/debug_link_top.sv
tests/link_tb.sv

// File: run.sh
#!/bin/sh
# build and run the debug link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module link_tb -f project.f -Mdir obj_dir -o link_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/link_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished cleanly"
exit 0

// File: tests/link_tb_host.svh
`ifndef LINK_TB_HOST_SVH
`define LINK_TB_HOST_SVH

// one word into the receive FIFO per cycle
task automatic push_word(input logic [WORD_W-1:0] w);
	@(negedge clock_i);
	rx_q.push_back(w);
endtask

// zero word, config word, start address
task automatic push_command(input logic [WORD_W-1:0] cfg, input logic [ADDR_W-1:0] addr);
	push_word('0);
	push_word(cfg);
	push_word(WORD_W'(addr));
endtask

// returned words in order, none missing
task automatic expect_words(input logic [WORD_W-1:0] exp[$]);
	logic [WORD_W-1:0] got;
	foreach (exp[i]) begin
		while (tx_q.size() == 0) @(negedge clock_i);
		got = tx_q.pop_front();
		check_equal("tx_data_o", got, exp[i]);
	end
endtask

`endif

// File: tests/link_tb.sv
`default_nettype none

module link_tb
	import link_pkg::*;
();

	localparam int PURGE_CYCLES = 16;
	localparam int RESET_CYCLES = 10;
	localparam int N_EARLY      = 3;
	localparam int N_SYNC       = 6;
	localparam int WR_N         = 8;
	localparam int RD_N         = 10;
	localparam int ERROR_HOLD   = 40;

	// early, sync, key, write, counted read, single read, bad frame words
	localparam int PUSHED = N_EARLY + N_SYNC + 1 + (3 + WR_N) + 3 + 3 + 4;
	localparam int WATCH_CYCLES = 2 * (RESET_CYCLES + PURGE_CYCLES + 24)
		+ 200 * PUSHED + ERROR_HOLD;

	logic              clock_i    = 1'b0;
	logic              resetn_i   = 1'b0;
	logic              rx_empty_i = 1'b1;
	logic [WORD_W-1:0] rx_data_i  = '0;
	logic              tx_full_i  = 1'b0;
	logic              ready_i    = 1'b0;
	logic              done_i     = 1'b0;
	logic [WORD_W-1:0] rdata_i    = '0;
	logic              rx_read_o;
	logic              tx_write_o;
	logic [WORD_W-1:0] tx_data_o;
	logic              req_o;
	logic              rw_o;
	logic [ADDR_W-1:0] addr_o;
	logic [WORD_W-1:0] wdata_o;
	logic              clear_o;
	logic              exception_o;

	// host FIFO contents and memory image
	logic [WORD_W-1:0] rx_q[$];
	logic [WORD_W-1:0] tx_q[$];
	logic [WORD_W-1:0] mem[logic [ADDR_W-1:0]];

	mem_req_t held_req;
	logic     in_flight   = 1'b0;
	int       done_wait   = -1;
	int       clear_count = 0;
	logic     in_reset_q  = 1'b0;

	debug_link_top #(
		.PURGE_CYCLES(PURGE_CYCLES)
	) dut (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.rx_empty_i  (rx_empty_i),
		.rx_data_i   (rx_data_i),
		.rx_read_o   (rx_read_o),
		.tx_full_i   (tx_full_i),
		.tx_write_o  (tx_write_o),
		.tx_data_o   (tx_data_o),
		.ready_i     (ready_i),
		.req_o       (req_o),
		.rw_o        (rw_o),
		.addr_o      (addr_o),
		.wdata_o     (wdata_o),
		.done_i      (done_i),
		.rdata_i     (rdata_i),
		.clear_o     (clear_o),
		.exception_o (exception_o)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] exp);
		assert (got === exp)
		else fail_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic check_low(input string name, input logic value);
		check_equal(name, WORD_W'(value), '0);
	endtask

	task automatic hold_reset();
		@(posedge clock_i);
		resetn_i <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_i);
		resetn_i <= 1'b1;
	endtask

	function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		// untouched locations read a pattern of their full address
		return {addr, 3'b011} ^ 32'h9E37_79B9;
	endfunction

	function automatic logic [WORD_W-1:0] config_word(input logic write, input logic counted,
		input int n);
		logic [WORD_W-1:0] cfg;
		cfg                = '0;
		cfg[CFG_WRITE_BIT] = write;
		cfg[CFG_COUNT_BIT] = counted;
		cfg[COUNT_W-1:0]   = COUNT_W'(n);
		return cfg;
	endfunction

	`include "link_tb_host.svh"

	initial begin
		forever #4 clock_i = ~clock_i;
	end

	// ------------------------------------------------------------------------
	// host FIFO and memory models
	// ------------------------------------------------------------------------

	always @(posedge clock_i) begin
		if (rx_read_o === 1'b1) begin
			assert (rx_q.size() > 0)
			else fail_run("receive FIFO popped while empty");
			void'(rx_q.pop_front());
		end
		rx_empty_i <= (rx_q.size() == 0);
		rx_data_i  <= (rx_q.size() == 0) ? '0 : rx_q[0];
		if (tx_write_o === 1'b1) begin
			tx_q.push_back(tx_data_o);
		end
		tx_full_i <= resetn_i && ($urandom_range(2, 0) == 0);
	end

	always @(posedge clock_i) begin
		if (!resetn_i) begin
			ready_i   <= 1'b0;
			done_i    <= 1'b0;
			in_flight = 1'b0;
			done_wait = -1;
		end else begin
			ready_i <= ($urandom_range(3, 0) != 0);
			done_i  <= 1'b0;
			// bus fields held from request through clear
			if (in_flight) begin
				check_equal("rw_o", WORD_W'(rw_o), WORD_W'(held_req.rw));
				check_equal("addr_o", WORD_W'(addr_o), WORD_W'(held_req.addr));
				check_equal("wdata_o", wdata_o, held_req.wdata);
			end
			if (clear_o === 1'b1) begin
				in_flight   = 1'b0;
				clear_count = clear_count + 1;
			end
			if (req_o === 1'b1) begin
				assert (!in_flight)
				else fail_run("second memory request before clear_o");
				in_flight = 1'b1;
				held_req  = '{rw: rw_o, addr: addr_o, wdata: wdata_o};
				done_wait = $urandom_range(3, 0);
				if (rw_o) begin
					mem[addr_o] = wdata_o;
				end
			end else if (done_wait == 0) begin
				done_i    <= 1'b1;
				rdata_i   <= mem_word(held_req.addr);
				done_wait = -1;
			end else if (done_wait > 0) begin
				done_wait = done_wait - 1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// protocol checks
	// ------------------------------------------------------------------------

	// outputs are known from the second reset edge on
	always @(posedge clock_i) begin
		if (in_reset_q) begin
			check_low("rx_read_o", rx_read_o);
			check_low("tx_write_o", tx_write_o);
			check_low("req_o", req_o);
			check_low("clear_o", clear_o);
			check_low("exception_o", exception_o);
		end
		in_reset_q = !resetn_i;
	end

	assert property (@(posedge clock_i) disable iff (!resetn_i) req_o |-> ready_i)
	else fail_run("req_o rose while ready_i was low");

	assert property (@(posedge clock_i) disable iff (!resetn_i) clear_o |-> $past(done_i))
	else fail_run("clear_o pulsed without done_i the cycle before");

	assert property (@(posedge clock_i) disable iff (!resetn_i) tx_write_o |-> !tx_full_i)
	else fail_run("tx_write_o pulsed while the transmit FIFO was full");

	assert property (@(posedge clock_i) disable iff (!resetn_i) exception_o |=> exception_o)
	else fail_run("exception_o dropped without a reset");

	initial begin
		repeat (WATCH_CYCLES) @(posedge clock_i);
		fail_run("watchdog expired before the tests finished");
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	initial begin
		logic [WORD_W-1:0] exp_q[$];
		logic [WORD_W-1:0] wr_data[$];
		logic [WORD_W-1:0] w;
		logic [ADDR_W-1:0] wr_addr;
		logic [ADDR_W-1:0] rd_addr;
		int                clears_before;

		void'($urandom(32'h1108_d188));
		hold_reset();

		// stale words dropped by the purge
		// gaps shorter than the quiet period restart the purge count
		for (int i = 0; i < N_EARLY; i++) begin
			push_word($urandom());
			repeat (PURGE_CYCLES - 4) @(negedge clock_i);
		end
		while (rx_q.size() != 0) @(negedge clock_i);
		repeat (PURGE_CYCLES + 4) @(negedge clock_i);
		assert (tx_q.size() == 0)
		else fail_run("a word pushed during the purge came back");

		for (int i = 0; i < N_SYNC; i++) begin
			w = $urandom();
			if (w == KEY_SYNC) begin
				w = ~w;
			end
			push_word(w);
			exp_q.push_back(w ^ XOR_SYNC);
		end
		push_word(KEY_SYNC);
		expect_words(exp_q);
		exp_q.delete();

		// counted write followed by one zero acknowledge
		wr_addr       = ADDR_W'({$urandom_range(32'h003F_FFFF, 0), 2'b00});
		clears_before = clear_count;
		push_command(config_word(1'b1, 1'b1, WR_N), wr_addr);
		for (int k = 0; k < WR_N; k++) begin
			w = $urandom();
			wr_data.push_back(w);
			push_word(w);
		end
		exp_q.push_back('0);
		expect_words(exp_q);
		exp_q.delete();
		check_equal("clear_o count", WORD_W'(clear_count - clears_before), WORD_W'(WR_N));
		for (int k = 0; k < WR_N; k++) begin
			check_equal("mem", mem_word(ADDR_W'(wr_addr + ADDR_STEP * k)), wr_data[k]);
		end

		// counted read over written and untouched words
		rd_addr = ADDR_W'(wr_addr + 8);
		for (int k = 0; k < RD_N; k++) begin
			exp_q.push_back(mem_word(ADDR_W'(rd_addr + ADDR_STEP * k)));
		end
		push_command(config_word(1'b0, 1'b1, RD_N), rd_addr);
		expect_words(exp_q);
		exp_q.delete();

		rd_addr = ADDR_W'(wr_addr + 32'h0001_0000);
		exp_q.push_back(mem_word(rd_addr));
		push_command(config_word(1'b0, 1'b0, 0), rd_addr);
		expect_words(exp_q);
		exp_q.delete();

		// bad frame start locks up until reset
		push_word(32'h0000_0001);
		while (exception_o !== 1'b1) @(negedge clock_i);
		push_command(config_word(1'b0, 1'b0, 0), rd_addr);
		repeat (ERROR_HOLD) begin
			@(negedge clock_i);
			check_equal("exception_o", WORD_W'(exception_o), 32'h1);
			check_low("req_o", req_o);
			check_low("tx_write_o", tx_write_o);
		end
		hold_reset();
		@(negedge clock_i);
		check_low("exception_o", exception_o);
		while (rx_q.size() != 0) @(negedge clock_i);
		repeat (PURGE_CYCLES + 4) @(negedge clock_i);
		assert (tx_q.size() == 0)
		else fail_run("unexpected words left in the transmit FIFO");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/debug_link_top.sv
`default_nettype none

module debug_link_top
	import link_pkg::*;
#(
	parameter int PURGE_CYCLES = 20000
) (
	input  wire logic              clock_i,
	input  wire logic              resetn_i,
	// host receive FIFO
	input  wire logic              rx_empty_i,
	input  wire logic [WORD_W-1:0] rx_data_i,
	output logic                   rx_read_o,
	// host transmit FIFO
	input  wire logic              tx_full_i,
	output logic                   tx_write_o,
	output logic [WORD_W-1:0]      tx_data_o,
	// memory bus
	input  wire logic              ready_i,
	output logic                   req_o,
	output logic                   rw_o,
	output logic [ADDR_W-1:0]      addr_o,
	output logic [WORD_W-1:0]      wdata_o,
	input  wire logic              done_i,
	input  wire logic [WORD_W-1:0] rdata_i,
	output logic                   clear_o,
	output logic                   exception_o
);

	logic              word_valid;
	logic [WORD_W-1:0] word;
	logic              word_take;

	logic              send_valid;
	logic [WORD_W-1:0] send_word;
	logic              send_ready;

	logic              cmd_valid;
	mem_req_t          cmd;
	logic              cmd_ready;
	logic              cmd_done;
	logic [WORD_W-1:0] bus_rdata;

	// ------------------------------------------------------------------------
	// host input
	// ------------------------------------------------------------------------

	link_word_receiver #(
		.PURGE_CYCLES(PURGE_CYCLES)
	) u_receiver (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.rx_empty_i   (rx_empty_i),
		.rx_data_i    (rx_data_i),
		.rx_read_o    (rx_read_o),
		.word_valid_o (word_valid),
		.word_o       (word),
		.word_take_i  (word_take)
	);

	// ------------------------------------------------------------------------
	// command processing
	// ------------------------------------------------------------------------

	link_sequencer u_sequencer (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.word_valid_i (word_valid),
		.word_i       (word),
		.word_take_o  (word_take),
		.send_valid_o (send_valid),
		.send_word_o  (send_word),
		.send_ready_i (send_ready),
		.cmd_valid_o  (cmd_valid),
		.cmd_o        (cmd),
		.cmd_ready_i  (cmd_ready),
		.cmd_done_i   (cmd_done),
		.rdata_i      (bus_rdata),
		.exception_o  (exception_o)
	);

	// ------------------------------------------------------------------------
	// memory and host outputs
	// ------------------------------------------------------------------------

	link_bus_master u_bus_master (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.cmd_valid_i (cmd_valid),
		.cmd_i       (cmd),
		.cmd_ready_o (cmd_ready),
		.cmd_done_o  (cmd_done),
		.rdata_o     (bus_rdata),
		.ready_i     (ready_i),
		.req_o       (req_o),
		.rw_o        (rw_o),
		.addr_o      (addr_o),
		.wdata_o     (wdata_o),
		.done_i      (done_i),
		.rdata_i     (rdata_i),
		.clear_o     (clear_o)
	);

	link_word_sender u_sender (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.send_valid_i (send_valid),
		.send_word_i  (send_word),
		.send_ready_o (send_ready),
		.tx_full_i    (tx_full_i),
		.tx_write_o   (tx_write_o),
		.tx_data_o    (tx_data_o)
	);

endmodule

`default_nettype wire

// File: source/link_word_sender.sv
`default_nettype none

module link_word_sender
	import link_pkg::*;
(
	input  wire logic              clock_i,
	input  wire logic              resetn_i,
	input  wire logic              send_valid_i,
	input  wire logic [WORD_W-1:0] send_word_i,
	output logic                   send_ready_o,
	input  wire logic              tx_full_i,
	output logic                   tx_write_o,
	output logic [WORD_W-1:0]      tx_data_o
);

	logic              full_q;
	logic [WORD_W-1:0] data_q;

	// drain whenever the FIFO has room
	assign tx_write_o = full_q && !tx_full_i;
	assign tx_data_o  = data_q;

	// slot frees up in the same cycle it drains
	assign send_ready_o = !full_q || !tx_full_i;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			full_q <= 1'b0;
		end else if (send_valid_i && send_ready_o) begin
			full_q <= 1'b1;
		end else if (tx_write_o) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (send_valid_i && send_ready_o) begin
			data_q <= send_word_i;
		end
	end

endmodule

`default_nettype wire

// File: source/link_bus_master.sv
`default_nettype none

module link_bus_master
	import link_pkg::*;
(
	input  wire logic              clock_i,
	input  wire logic              resetn_i,
	// command side
	input  wire logic              cmd_valid_i,
	input  wire mem_req_t          cmd_i,
	output logic                   cmd_ready_o,
	output logic                   cmd_done_o,
	output logic [WORD_W-1:0]      rdata_o,
	// memory side
	input  wire logic              ready_i,
	output logic                   req_o,
	output logic                   rw_o,
	output logic [ADDR_W-1:0]      addr_o,
	output logic [WORD_W-1:0]      wdata_o,
	input  wire logic              done_i,
	input  wire logic [WORD_W-1:0] rdata_i,
	output logic                   clear_o
);

	typedef enum logic [1:0] {
		BM_IDLE,
		BM_WAIT_READY,
		BM_WAIT_DONE,
		BM_CLEAR
	} bm_state_t;

	bm_state_t         state_q;
	mem_req_t          req_q;
	logic [WORD_W-1:0] rdata_q;

	// ------------------------------------------------------------------------
	// handshake sequencing
	// ------------------------------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= BM_IDLE;
		end else begin
			case (state_q)
				BM_IDLE: begin
					if (cmd_valid_i) begin
						state_q <= BM_WAIT_READY;
					end
				end
				// request goes out in the cycle ready is seen
				BM_WAIT_READY: begin
					if (ready_i) begin
						state_q <= BM_WAIT_DONE;
					end
				end
				BM_WAIT_DONE: begin
					if (done_i) begin
						state_q <= BM_CLEAR;
					end
				end
				default: state_q <= BM_IDLE;
			endcase
		end
	end

	// command and read data holding
	always_ff @(posedge clock_i) begin
		if (state_q == BM_IDLE && cmd_valid_i) begin
			req_q <= cmd_i;
		end
		if (state_q == BM_WAIT_DONE && done_i) begin
			rdata_q <= rdata_i;
		end
	end

	assign cmd_ready_o = (state_q == BM_IDLE);
	assign req_o       = (state_q == BM_WAIT_READY) && ready_i;
	assign clear_o     = (state_q == BM_CLEAR);
	assign cmd_done_o  = clear_o;

	// held from request through clear
	assign rw_o    = req_q.rw;
	assign addr_o  = req_q.addr;
	assign wdata_o = req_q.wdata;
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/link_sequencer.sv
`default_nettype none

module link_sequencer
	import link_pkg::*;
(
	input  wire logic              clock_i,
	input  wire logic              resetn_i,
	// from the word receiver
	input  wire logic              word_valid_i,
	input  wire logic [WORD_W-1:0] word_i,
	output logic                   word_take_o,
	// to the word sender
	output logic                   send_valid_o,
	output logic [WORD_W-1:0]      send_word_o,
	input  wire logic              send_ready_i,
	// to the bus master
	output logic                   cmd_valid_o,
	output mem_req_t               cmd_o,
	input  wire logic              cmd_ready_i,
	input  wire logic              cmd_done_i,
	input  wire logic [WORD_W-1:0] rdata_i,
	output logic                   exception_o
);

	typedef enum logic [3:0] {
		ST_SYNC,
		ST_IDLE,
		ST_CONFIG,
		ST_ADDR,
		ST_WR_DATA,
		ST_MEM,
		ST_MEM_WAIT,
		ST_RD_SEND,
		ST_ACK,
		ST_ERROR
	} state_t;

	localparam logic [ADDR_W-1:0] STEP = ADDR_W'(ADDR_STEP);

	state_t             state_q;
	logic [COUNT_W-1:0] count_q;
	logic               write_q;
	logic [ADDR_W-1:0]  addr_q;
	logic [WORD_W-1:0]  wdata_q;

	logic word_move;
	logic send_move;
	logic last_word;

	assign word_move = word_valid_i && word_take_o;
	assign send_move = send_valid_o && send_ready_i;
	assign last_word = (count_q == COUNT_W'(1));

	// ------------------------------------------------------------------------
	// state and transfer registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= ST_SYNC;
			count_q <= '0;
			write_q <= 1'b0;
			addr_q  <= '0;
		end else begin
			case (state_q)
				ST_SYNC: begin
					if (word_move && word_i == KEY_SYNC) begin
						state_q <= ST_IDLE;
					end
				end
				// every command opens with a zero word
				ST_IDLE: begin
					if (word_move) begin
						state_q <= (word_i == '0) ? ST_CONFIG : ST_ERROR;
					end
				end
				ST_CONFIG: begin
					if (word_move) begin
						write_q <= word_i[CFG_WRITE_BIT];
						if (!word_i[CFG_COUNT_BIT]) begin
							count_q <= COUNT_W'(1);
							state_q <= ST_ADDR;
						end else if (word_i[COUNT_W-1:0] == '0) begin
							state_q <= ST_ERROR;
						end else begin
							count_q <= word_i[COUNT_W-1:0];
							state_q <= ST_ADDR;
						end
					end
				end
				ST_ADDR: begin
					if (word_move) begin
						addr_q  <= word_i[ADDR_W-1:0];
						state_q <= write_q ? ST_WR_DATA : ST_MEM;
					end
				end
				ST_WR_DATA: begin
					if (word_move) begin
						state_q <= ST_MEM;
					end
				end
				ST_MEM: begin
					if (cmd_ready_i) begin
						state_q <= ST_MEM_WAIT;
					end
				end
				ST_MEM_WAIT: begin
					if (cmd_done_i) begin
						if (!write_q) begin
							state_q <= ST_RD_SEND;
						end else if (last_word) begin
							state_q <= ST_ACK;
						end else begin
							count_q <= count_q - 1'b1;
							addr_q  <= addr_q + STEP;
							state_q <= ST_WR_DATA;
						end
					end
				end
				// read data stays on rdata_i while the bus master idles
				ST_RD_SEND: begin
					if (send_move) begin
						if (last_word) begin
							state_q <= ST_IDLE;
						end else begin
							count_q <= count_q - 1'b1;
							addr_q  <= addr_q + STEP;
							state_q <= ST_MEM;
						end
					end
				end
				ST_ACK: begin
					if (send_move) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_ERROR;
			endcase
		end
	end

	// pending write data
	always_ff @(posedge clock_i) begin
		if (state_q == ST_WR_DATA && word_move) begin
			wdata_q <= word_i;
		end
	end

	// ------------------------------------------------------------------------
	// handshake outputs
	// ------------------------------------------------------------------------

	always_comb begin
		word_take_o  = 1'b0;
		send_valid_o = 1'b0;
		send_word_o  = '0;
		case (state_q)
			// take a word only when its echo has room
			ST_SYNC: begin
				word_take_o  = send_ready_i;
				send_valid_o = word_valid_i && (word_i != KEY_SYNC);
				send_word_o  = word_i ^ XOR_SYNC;
			end
			ST_IDLE, ST_CONFIG, ST_ADDR, ST_WR_DATA: word_take_o = 1'b1;
			ST_RD_SEND: begin
				send_valid_o = 1'b1;
				send_word_o  = rdata_i;
			end
			ST_ACK: send_valid_o = 1'b1;
			default: ;
		endcase
	end

	assign cmd_valid_o = (state_q == ST_MEM);
	assign cmd_o       = '{rw: write_q, addr: addr_q, wdata: wdata_q};
	assign exception_o = (state_q == ST_ERROR);

endmodule

`default_nettype wire

// File: source/link_word_receiver.sv
`default_nettype none

module link_word_receiver
	import link_pkg::*;
#(
	parameter int PURGE_CYCLES = 20000
) (
	input  wire logic              clock_i,
	input  wire logic              resetn_i,
	input  wire logic              rx_empty_i,
	input  wire logic [WORD_W-1:0] rx_data_i,
	output logic                   rx_read_o,
	output logic                   word_valid_o,
	output logic [WORD_W-1:0]      word_o,
	input  wire logic              word_take_i
);

	localparam int CNT_W = $clog2(PURGE_CYCLES + 1);
	localparam logic [CNT_W-1:0] PURGE_LAST = CNT_W'(PURGE_CYCLES);

	typedef enum logic [1:0] {
		PH_WAKE,
		PH_PURGE,
		PH_PASS
	} phase_t;

	phase_t           phase_q;
	logic [CNT_W-1:0] quiet_cnt_q;

	// ------------------------------------------------------------------------
	// purge sequencing
	// ------------------------------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			phase_q     <= PH_WAKE;
			quiet_cnt_q <= '0;
		end else begin
			case (phase_q)
				// one idle cycle before touching the FIFO
				PH_WAKE: phase_q <= PH_PURGE;
				PH_PURGE: begin
					if (!rx_empty_i) begin
						quiet_cnt_q <= '0;
					end else if (quiet_cnt_q == PURGE_LAST) begin
						phase_q <= PH_PASS;
					end else begin
						quiet_cnt_q <= quiet_cnt_q + 1'b1;
					end
				end
				default: phase_q <= PH_PASS;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// FIFO access
	// ------------------------------------------------------------------------

	assign word_o       = rx_data_i;
	assign word_valid_o = (phase_q == PH_PASS) && !rx_empty_i;

	always_comb begin
		case (phase_q)
			// stale words are dropped as they show up
			PH_PURGE: rx_read_o = !rx_empty_i;
			PH_PASS:  rx_read_o = word_valid_o && word_take_i;
			default:  rx_read_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/link_pkg.sv
`default_nettype none

package link_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------

	// host words and memory data share one width
	parameter int WORD_W = 32;

	// byte address, 512 MB memory space
	parameter int ADDR_W = 29;

	// word count field of a config word
	parameter int COUNT_W = 12;

	// byte step between consecutive words
	parameter int ADDR_STEP = 4;

	// ------------------------------------------------------------------------
	// sync handshake
	// ------------------------------------------------------------------------

	// host sends this to leave sync
	parameter logic [WORD_W-1:0] KEY_SYNC = 32'h4A78_B9F2;

	// echo mask while in sync
	parameter logic [WORD_W-1:0] XOR_SYNC = 32'hCD00_31F7;

	// ------------------------------------------------------------------------
	// config word layout
	// ------------------------------------------------------------------------

	// bits 11..0 carry the count when the counted flag is set
	parameter int CFG_WRITE_BIT = 12;
	parameter int CFG_COUNT_BIT = 13;

	// one memory transaction, rw high means write
	typedef struct packed {
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire
